// File: mc_defs.svh
// mini chipset shared constants
// bus widths, address map and timer timing

`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// bus widths
`define MC_ADDR_W     24
`define MC_DATA_W     16

// chip ram, mirrored over the whole chip region
`define MC_RAM_WORDS  256
`define MC_RAM_AW     8

// ----------------------------------------------------------
// address map
// ----------------------------------------------------------
`define MC_CHIP_BASE  24'h000000
`define MC_CHIP_TOP   24'h07FFFF
`define MC_CIAA_BASE  24'hBFE000
`define MC_CIAA_SIZE  24'h001000
`define MC_CUST_BASE  24'hDFF000
`define MC_CUST_SIZE  24'h000200
`define MC_ROM_BASE   24'hF80000

// kickstart pattern seed, xor'ed with word address
`define MC_ROM_SEED   16'hA55A

// clocks per e-clock tick
`define MC_ECLK_DIV   10

`endif

// File: mc_bus_pkg.sv
// system bus types
// apb request/response, target select and the decoded access given to each unit
`default_nettype none
`include "mc_defs.svh"

package mc_bus_pkg;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [`MC_ADDR_W-1:0] paddr;
		logic [`MC_DATA_W-1:0] pwdata;
		logic [1:0]            pstrb;   // [1] upper byte, [0] lower byte
	} apb_req_t;

	typedef struct packed {
		logic [`MC_DATA_W-1:0] prdata;
		logic                  pready;
		logic                  pslverr;
	} apb_rsp_t;

	typedef enum logic [2:0] {
		T_NONE,  // unmapped
		T_RAM,
		T_ROM,
		T_CUST,
		T_CIAA
	} target_e;

	// one decoded access, fans out to all units
	typedef struct packed {
		target_e               target;
		logic [8:0]            offset;  // custom reg offset or cia index
		logic [15:0]           waddr;   // word address, paddr[16:1]
		logic                  write;
		logic [`MC_DATA_W-1:0] wdata;
		logic [1:0]            strb;
		logic                  setup;   // psel without penable
		logic                  access;  // psel with penable
	} access_t;

endpackage

`default_nettype wire

// File: mc_chip_pkg.sv
// chipset side types
// custom register offsets, cia register indices, unit response
`default_nettype none
`include "mc_defs.svh"

package mc_chip_pkg;

	// paula interrupt registers, byte offsets from dff000
	typedef enum logic [8:0] {
		INTENAR = 9'h01C,
		INTREQR = 9'h01E,
		INTENA  = 9'h09A,
		INTREQ  = 9'h09C
	} cust_reg_e;

	// cia register select, address bits 11..8
	typedef enum logic [3:0] {
		PRA  = 4'd0,
		DDRA = 4'd2,
		TALO = 4'd4,
		TAHI = 4'd5,
		ICR  = 4'd13,
		CRA  = 4'd14
	} cia_reg_e;

	typedef struct packed {
		logic [`MC_DATA_W-1:0] rdata;
		logic                  ready;
	} unit_rsp_t;

endpackage

`default_nettype wire

// File: addr_decode.sv
// address decoder for the system bus
// sorts each apb access into ram, rom, custom or cia-a, boot overlay applied
`timescale 1ns/10ps
`default_nettype none
`include "mc_defs.svh"

module addr_decode import mc_bus_pkg::*; (
	input  wire           clk,
	input  wire           reset,
	input  wire apb_req_t apb_req_i,
	input  wire           ovl_i,     // kickstart overlay from cia-a
	output access_t       acc_o
);

	logic [`MC_ADDR_W-1:0] addr;
	logic in_chip;
	logic in_ciaa;
	logic in_cust;
	logic in_rom;
	target_e tgt;

	assign addr = apb_req_i.paddr;

	// unsigned range checks, wrap below base gives a large value
	assign in_chip = (addr - `MC_CHIP_BASE) <= (`MC_CHIP_TOP - `MC_CHIP_BASE);
	assign in_ciaa = (addr - `MC_CIAA_BASE) < `MC_CIAA_SIZE;
	assign in_cust = (addr - `MC_CUST_BASE) < `MC_CUST_SIZE;
	assign in_rom  = addr >= `MC_ROM_BASE;

	always_comb begin
		tgt = T_NONE;
		if (in_chip)
			tgt = (ovl_i && !apb_req_i.pwrite) ? T_ROM : T_RAM; // overlay hits reads only
		else if (in_ciaa)
			tgt = T_CIAA;
		else if (in_cust)
			tgt = T_CUST;
		else if (in_rom)
			tgt = T_ROM;
	end

	always_comb begin
		acc_o.target = tgt;
		acc_o.offset = (tgt == T_CIAA) ? {5'd0, addr[11:8]} : addr[8:0];
		acc_o.waddr  = addr[16:1];
		acc_o.write  = apb_req_i.pwrite;
		acc_o.wdata  = apb_req_i.pwdata;
		acc_o.strb   = apb_req_i.pstrb;
		acc_o.setup  = apb_req_i.psel && !apb_req_i.penable;
		acc_o.access = apb_req_i.psel && apb_req_i.penable;
	end

	// setup phase always moves on to an access with the same address
	a_setup_to_access: assert property (@(posedge clk) disable iff (reset)
		acc_o.setup |=> acc_o.access && $stable(apb_req_i.paddr));

endmodule

`default_nettype wire

// File: chip_mem.sv
// chip ram with byte strobes and one read wait state
// plus the generated kickstart rom
`timescale 1ns/10ps
`default_nettype none
`include "mc_defs.svh"

module chip_mem import mc_bus_pkg::*, mc_chip_pkg::*; (
	input  wire          clk,
	input  wire          reset,
	input  wire access_t acc_i,
	output unit_rsp_t    rsp_o
);

	logic [`MC_DATA_W-1:0] ram [`MC_RAM_WORDS];
	logic [`MC_DATA_W-1:0] rd_q;      // registered ram word
	logic [`MC_DATA_W-1:0] rom_word;
	logic [`MC_RAM_AW-1:0] idx;
	logic ram_sel;
	logic ram_wr;
	logic ram_rd;
	logic rom_sel;
	logic rd_pend;                    // read launched last cycle

	assign idx      = acc_i.waddr[`MC_RAM_AW-1:0]; // mirrors over chip region
	assign ram_sel  = acc_i.access && (acc_i.target == T_RAM);
	assign ram_wr   = ram_sel && acc_i.write;
	assign ram_rd   = ram_sel && !acc_i.write && !rd_pend;
	assign rom_sel  = acc_i.access && (acc_i.target == T_ROM);
	assign rom_word = acc_i.waddr ^ `MC_ROM_SEED;

	always_ff @(posedge clk) begin
		if (ram_wr && acc_i.strb[0])
			ram[idx][7:0] <= acc_i.wdata[7:0];
		if (ram_wr && acc_i.strb[1])
			ram[idx][15:8] <= acc_i.wdata[15:8];
		if (ram_rd)
			rd_q <= ram[idx];
	end

	always_ff @(posedge clk) begin
		if (reset)
			rd_pend <= 1'b0;
		else
			rd_pend <= ram_rd; // high for exactly one cycle
	end

	always_comb begin
		rsp_o.ready = ram_wr || rd_pend || rom_sel;
		rsp_o.rdata = '0;
		if (rd_pend)
			rsp_o.rdata = rd_q;
		else if (rom_sel)
			rsp_o.rdata = rom_word;
	end

	// every launched ram read completes on the next access cycle
	a_read_done: assert property (@(posedge clk) disable iff (reset)
		ram_rd |=> rsp_o.ready && acc_i.access);

endmodule

`default_nettype wire

// File: paula_int.sv
// paula interrupt controller
// intena/intreq with set/clear writes, 68000 priority level encoder
`timescale 1ns/10ps
`default_nettype none

module paula_int import mc_bus_pkg::*, mc_chip_pkg::*; (
	input  wire          clk,
	input  wire          reset,
	input  wire access_t acc_i,
	input  wire          ports_irq_i,  // level request from cia-a
	output unit_rsp_t    rsp_o,
	output logic [2:0]   ipl_o
);

	logic [14:0] intena;
	logic [14:0] intreq;
	logic [14:0] ena_nxt;
	logic [14:0] req_nxt;
	logic [14:0] active;
	logic cust_wr;

	assign cust_wr = acc_i.access && acc_i.write && (acc_i.target == T_CUST);

	// bit 15 chooses set or clear for the other bits
	always_comb begin
		ena_nxt = intena;
		req_nxt = intreq;
		if (cust_wr && acc_i.offset == INTENA)
			ena_nxt = acc_i.wdata[15] ? (intena | acc_i.wdata[14:0])
			                          : (intena & ~acc_i.wdata[14:0]);
		if (cust_wr && acc_i.offset == INTREQ)
			req_nxt = acc_i.wdata[15] ? (intreq | acc_i.wdata[14:0])
			                          : (intreq & ~acc_i.wdata[14:0]);
		req_nxt[3] = req_nxt[3] | ports_irq_i; // ports, wins over a clear
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			intena <= '0;
			intreq <= '0;
		end else begin
			intena <= ena_nxt;
			intreq <= req_nxt;
		end
	end

	// ----------------------------------------------------------
	// register read back
	// ----------------------------------------------------------
	always_comb begin
		rsp_o.ready = acc_i.access && (acc_i.target == T_CUST);
		case (cust_reg_e'(acc_i.offset))
			INTENAR: rsp_o.rdata = {1'b0, intena};
			INTREQR: rsp_o.rdata = {1'b0, intreq};
			default: rsp_o.rdata = '0;
		endcase
	end

	// ----------------------------------------------------------
	// priority encoder, master enable in intena[14]
	// ----------------------------------------------------------
	assign active = intena & intreq & {15{intena[14]}};

	always_comb begin
		if (active[13])
			ipl_o = 3'd6;
		else if (|active[12:11])
			ipl_o = 3'd5;
		else if (|active[10:7])
			ipl_o = 3'd4;
		else if (|active[6:4])
			ipl_o = 3'd3;
		else if (active[3])
			ipl_o = 3'd2;
		else if (|active[2:0])
			ipl_o = 3'd1;
		else
			ipl_o = 3'd0;
	end

	// level 7 belongs to nmi, never raised from here
	a_no_nmi: assert property (@(posedge clk) disable iff (reset) ipl_o != 3'd7);

endmodule

`default_nettype wire

// File: cia_a.sv
// cia-a subset: port a with ddra, timer a on the e-clock, icr
// port a bits 0 and 1 give the overlay and the power led
`timescale 1ns/10ps
`default_nettype none
`include "mc_defs.svh"

module cia_a import mc_bus_pkg::*, mc_chip_pkg::*; (
	input  wire          clk,
	input  wire          reset,
	input  wire access_t acc_i,
	input  wire [7:0]    port_i,
	output unit_rsp_t    rsp_o,
	output logic         ovl_o,
	output logic         led_o,
	output logic         irq_o
);

	logic [7:0] pra;
	logic [7:0] ddra;
	logic [7:0] cra;       // [0] start, [3] one-shot
	logic [7:0] pins;
	logic [7:0] ext;
	logic [7:0] rd_byte;
	logic [7:0] wd;
	logic [3:0] rs;
	logic [15:0] ta_latch;
	logic [15:0] ta_cnt;
	logic [$clog2(`MC_ECLK_DIV)-1:0] ediv;
	logic eclk_tick;
	logic ta_uflow;
	logic icr_flag;        // timer a flag
	logic icr_mask;
	logic sel;
	logic wr;
	logic rd;

	assign sel = acc_i.access && (acc_i.target == T_CIAA);
	assign wr  = sel && acc_i.write;
	assign rd  = sel && !acc_i.write;
	assign rs  = acc_i.offset[3:0];
	assign wd  = acc_i.wdata[7:0]; // cia sits on the low byte

	// ----------------------------------------------------------
	// port a
	// ----------------------------------------------------------
	assign ext   = {port_i[7:2], 2'b11}; // ovl and led pins pulled up
	assign pins  = (ddra & pra) | (~ddra & ext);
	assign ovl_o = pins[0];
	assign led_o = ~pins[1];             // led lit when pin low

	always_ff @(posedge clk) begin
		if (reset) begin
			pra  <= '0;
			ddra <= '0;
		end else begin
			if (wr && rs == PRA)
				pra <= wd;
			if (wr && rs == DDRA)
				ddra <= wd;
		end
	end

	// ----------------------------------------------------------
	// timer a
	// ----------------------------------------------------------
	assign eclk_tick = (ediv == `MC_ECLK_DIV - 1);
	assign ta_uflow  = eclk_tick && cra[0] && (ta_cnt == '0);

	always_ff @(posedge clk) begin
		if (reset || eclk_tick)
			ediv <= '0;
		else
			ediv <= ediv + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ta_latch <= 16'hFFFF;
			ta_cnt   <= 16'hFFFF;
			cra      <= '0;
		end else begin
			if (wr && rs == TALO)
				ta_latch[7:0] <= wd;
			if (wr && rs == TAHI)
				ta_latch[15:8] <= wd;
			if (ta_uflow)
				ta_cnt <= ta_latch;                 // reload
			else if (eclk_tick && cra[0])
				ta_cnt <= ta_cnt - 1'b1;
			else if (wr && rs == TAHI && !cra[0])
				ta_cnt <= {wd, ta_latch[7:0]};      // load while stopped
			if (ta_uflow && cra[3])
				cra[0] <= 1'b0;                     // one-shot stops
			if (wr && rs == CRA)
				cra <= wd;
		end
	end

	// ----------------------------------------------------------
	// icr, flag cleared by read
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			icr_flag <= 1'b0;
			icr_mask <= 1'b0;
		end else begin
			if (wr && rs == ICR)
				icr_mask <= wd[7] ? (icr_mask | wd[0]) : (icr_mask & ~wd[0]);
			if (ta_uflow)
				icr_flag <= 1'b1;
			else if (rd && rs == ICR)
				icr_flag <= 1'b0;
		end
	end

	assign irq_o = icr_flag & icr_mask;

	always_comb begin
		case (cia_reg_e'(rs))
			PRA:     rd_byte = pins;
			DDRA:    rd_byte = ddra;
			TALO:    rd_byte = ta_cnt[7:0];
			TAHI:    rd_byte = ta_cnt[15:8];
			ICR:     rd_byte = {irq_o, 6'd0, icr_flag};
			CRA:     rd_byte = cra;
			default: rd_byte = 8'h00;
		endcase
	end

	assign rsp_o = '{rdata: {8'h00, rd_byte}, ready: sel};

	// stopped timer only moves on a tahi load
	a_cnt_hold: assert property (@(posedge clk) disable iff (reset)
		!cra[0] && !(wr && rs == TAHI) |=> $stable(ta_cnt));

endmodule

`default_nettype wire

// File: read_mux.sv
// response merge for the apb side
// picks the unit by target, flags unmapped and rom writes
`timescale 1ns/10ps
`default_nettype none

module read_mux import mc_bus_pkg::*, mc_chip_pkg::*; (
	input  wire access_t   acc_i,
	input  wire unit_rsp_t ram_rsp_i,  // chip ram and rom
	input  wire unit_rsp_t int_rsp_i,  // paula
	input  wire unit_rsp_t cia_rsp_i,
	output apb_rsp_t       apb_rsp_o
);

	unit_rsp_t sel;
	logic err;
	logic rdy;

	always_comb begin
		case (acc_i.target)
			T_RAM,
			T_ROM:   sel = ram_rsp_i;
			T_CUST:  sel = int_rsp_i;
			T_CIAA:  sel = cia_rsp_i;
			default: sel = '0;
		endcase
	end

	// error completes at once, nothing below sees a state change
	assign err = acc_i.access && ((acc_i.target == T_NONE) ||
	                              (acc_i.target == T_ROM && acc_i.write));
	assign rdy = err || (acc_i.access && sel.ready);

	always_comb begin
		apb_rsp_o.pready  = rdy;
		apb_rsp_o.pslverr = err;
		apb_rsp_o.prdata  = '0;
		if (rdy && !err && !acc_i.write)
			apb_rsp_o.prdata = sel.rdata; // data only with pready
	end

endmodule

`default_nettype wire

// File: mini_chipset.sv
// mini chipset top level
// decoder, ram/rom, interrupt controller, cia-a and response merge
`timescale 1ns/10ps
`default_nettype none

module mini_chipset import mc_bus_pkg::*, mc_chip_pkg::*; (
	input  wire           clk,
	input  wire           reset,
	input  wire apb_req_t apb_req_i,
	input  wire [7:0]     port_i,
	output apb_rsp_t      apb_rsp_o,
	output logic [2:0]    ipl_o,
	output logic          led_o
);

	access_t   acc;
	unit_rsp_t ram_rsp;
	unit_rsp_t int_rsp;
	unit_rsp_t cia_rsp;
	logic      ovl;       // boot overlay, cia-a pa0
	logic      ciaa_irq;  // into intreq ports

	// ----------------------------------------------------------
	// decode
	// ----------------------------------------------------------
	addr_decode u_decode (
		.clk       (clk),
		.reset     (reset),
		.apb_req_i (apb_req_i),
		.ovl_i     (ovl),
		.acc_o     (acc)
	);

	// ----------------------------------------------------------
	// execute
	// ----------------------------------------------------------
	chip_mem u_mem (
		.clk   (clk),
		.reset (reset),
		.acc_i (acc),
		.rsp_o (ram_rsp)
	);

	paula_int u_paula (
		.clk         (clk),
		.reset       (reset),
		.acc_i       (acc),
		.ports_irq_i (ciaa_irq),
		.rsp_o       (int_rsp),
		.ipl_o       (ipl_o)
	);

	cia_a u_ciaa (
		.clk    (clk),
		.reset  (reset),
		.acc_i  (acc),
		.port_i (port_i),
		.rsp_o  (cia_rsp),
		.ovl_o  (ovl),
		.led_o  (led_o),
		.irq_o  (ciaa_irq)
	);

	// result
	read_mux u_rmux (
		.acc_i     (acc),
		.ram_rsp_i (ram_rsp),
		.int_rsp_i (int_rsp),
		.cia_rsp_i (cia_rsp),
		.apb_rsp_o (apb_rsp_o)
	);

endmodule

`default_nettype wire

// File: tb_mini_chipset.sv
// testbench for the mini chipset
// table of apb steps with expected data, pslverr, wait states, ipl and led
`timescale 1ns/10ps
`default_nettype none
`include "mc_defs.svh"

module tb_mini_chipset import mc_bus_pkg::*; ();

	localparam logic [1:0] OP_WRITE = 2'd0;
	localparam logic [1:0] OP_READ  = 2'd1;
	localparam logic [1:0] OP_WAIT  = 2'd2;

	typedef struct packed {
		logic [1:0]  op;
		logic [23:0] addr;
		logic [15:0] data;      // cycle count for a wait step
		logic [1:0]  strb;
		logic [15:0] exp_data;
		logic        exp_err;
		logic [1:0]  exp_wait;  // cycles with pready low
		logic [2:0]  exp_ipl;
		logic        exp_led;
	} step_t;

	logic clk;
	logic reset;
	apb_req_t req;
	apb_rsp_t rsp;
	logic [7:0] port;
	logic [2:0] ipl;
	logic led;

	step_t steps[$];
	logic [31:0] rnd;       // lcg state
	int budget;             // cycles the table should need
	int limit_ns;
	int err_data;
	int err_rsp;
	int err_pin;

	mini_chipset DUT (
		.clk       (clk),
		.reset     (reset),
		.apb_req_i (req),
		.port_i    (port),
		.apb_rsp_o (rsp),
		.ipl_o     (ipl),
		.led_o     (led)
	);

	always #10 clk = ~clk;

	// ----------------------------------------------------------
	// reference rules and table builders
	// ----------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [15:0] rom_pattern(input logic [23:0] a);
		return a[16:1] ^ `MC_ROM_SEED;    // word address xor seed
	endfunction

	// strobe bit 1 takes the upper byte, bit 0 the lower
	function automatic logic [15:0] merge_bytes(input logic [15:0] old_w,
			input logic [15:0] new_w, input logic [1:0] strb);
		return {strb[1] ? new_w[15:8] : old_w[15:8], strb[0] ? new_w[7:0] : old_w[7:0]};
	endfunction

	task automatic write_step(input logic [23:0] addr, input logic [15:0] data,
			input logic [1:0] strb, input logic err, input logic [2:0] ipl_e,
			input logic led_e);
		steps.push_back({OP_WRITE, addr, data, strb, 16'h0000, err, 2'd0, ipl_e, led_e});
		budget += 5;
	endtask

	task automatic read_step(input logic [23:0] addr, input logic [15:0] exp,
			input logic err, input logic [1:0] wait_e, input logic [2:0] ipl_e,
			input logic led_e);
		steps.push_back({OP_READ, addr, 16'h0000, 2'b11, exp, err, wait_e, ipl_e, led_e});
		budget += 5;
	endtask

	task automatic idle_step(input logic [15:0] cycles, input logic [2:0] ipl_e,
			input logic led_e);
		steps.push_back({OP_WAIT, 24'h0, cycles, 2'b00, 16'h0000, 1'b0, 2'd0, ipl_e, led_e});
		budget += cycles + 2;
	endtask

	// one apb transfer, counts access cycles with pready low
	task automatic bus_xfer(input step_t st, output logic [15:0] rdata,
			output logic err, output int waits);
		apb_req_t nxt;
		nxt        = '0;
		nxt.psel   = 1'b1;
		nxt.pwrite = (st.op == OP_WRITE);
		nxt.paddr  = st.addr;
		nxt.pwdata = st.data;
		nxt.pstrb  = st.strb;
		waits      = 0;
		@(posedge clk);
		req <= nxt;                       // setup
		nxt.penable = 1'b1;
		@(posedge clk);
		req <= nxt;                       // first access cycle
		@(negedge clk);
		while (rsp.pready !== 1'b1) begin
			waits++;
			@(negedge clk);
		end
		rdata = rsp.prdata;
		err   = rsp.pslverr;
		@(posedge clk);                   // commit edge
		req <= '0;
	endtask

	// hang guard, limit set once the table is built
	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		$display("timeout: no finish within %0d ns, the DUT stopped answering", limit_ns);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		step_t st;
		logic [15:0] rdata;
		logic err;
		int waits;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] first;
		logic [23:0] ram_addr;

		clk      = 1'b0;
		reset    = 1'b1;
		req      = '0;
		port     = 8'hA4;
		rnd      = 32'd71;
		budget   = 3;
		limit_ns = 0;
		err_data = 0;
		err_rsp  = 0;
		err_pin  = 0;
		first    = '0;

		// ----------------------------------------------------------
		// overlay, then ram byte strobes and rom reads
		// ----------------------------------------------------------
		read_step(24'h000010, rom_pattern(24'h000010), 1'b0, 2'd0, 3'd0, 1'b0); // boot rom
		write_step(24'hBFE200, 16'h0003, 2'b01, 1'b0, 3'd0, 1'b1);  // ddra, pa1 low lights led
		write_step(24'hBFE000, 16'h0000, 2'b01, 1'b0, 3'd0, 1'b1);  // pra, overlay off
		read_step(24'hBFE000, 16'h00A4, 1'b0, 2'd0, 3'd0, 1'b1);    // pins, low two driven
		for (int k = 0; k < 4; k++) begin
			ram_addr = 24'h000040 + 24'(4 * k);
			rnd = lcg_next(rnd);
			a = rnd[31:16];
			rnd = lcg_next(rnd);
			b = rnd[31:16];
			write_step(ram_addr, a, 2'b11, 1'b0, 3'd0, 1'b1);
			write_step(ram_addr, b, 2'(k), 1'b0, 3'd0, 1'b1);
			read_step(ram_addr, merge_bytes(a, b, 2'(k)), 1'b0, 2'd1, 3'd0, 1'b1);
			if (k == 0)
				first = merge_bytes(a, b, 2'(k));
		end
		read_step(24'h001040, first, 1'b0, 2'd1, 3'd0, 1'b1);       // ram mirror
		read_step(24'hF80010, rom_pattern(24'hF80010), 1'b0, 2'd0, 3'd0, 1'b1);
		read_step(24'hFC1234, rom_pattern(24'hFC1234), 1'b0, 2'd0, 3'd0, 1'b1);

		// ----------------------------------------------------------
		// intena / intreq and the level table
		// ----------------------------------------------------------
		write_step(24'hDFF09C, 16'h8011, 2'b11, 1'b0, 3'd0, 1'b1);
		write_step(24'hDFF09A, 16'h8011, 2'b11, 1'b0, 3'd0, 1'b1);  // no master yet
		read_step(24'hDFF01C, 16'h0011, 1'b0, 2'd0, 3'd0, 1'b1);
		read_step(24'hDFF01E, 16'h0011, 1'b0, 2'd0, 3'd0, 1'b1);
		write_step(24'hDFF09A, 16'hC000, 2'b11, 1'b0, 3'd3, 1'b1);  // master on
		write_step(24'hDFF09C, 16'hA000, 2'b11, 1'b0, 3'd3, 1'b1);
		write_step(24'hDFF09A, 16'hA800, 2'b11, 1'b0, 3'd6, 1'b1);
		write_step(24'hDFF09C, 16'h2000, 2'b11, 1'b0, 3'd3, 1'b1);  // clear bit 13
		write_step(24'hDFF09C, 16'h8800, 2'b11, 1'b0, 3'd5, 1'b1);
		write_step(24'hDFF09C, 16'h0810, 2'b11, 1'b0, 3'd1, 1'b1);
		write_step(24'hDFF09A, 16'h4000, 2'b11, 1'b0, 3'd0, 1'b1);  // master off
		read_step(24'hDFF01C, 16'h2811, 1'b0, 2'd0, 3'd0, 1'b1);
		read_step(24'hDFF01E, 16'h0001, 1'b0, 2'd0, 3'd0, 1'b1);
		write_step(24'hDFF09C, 16'h7FFF, 2'b11, 1'b0, 3'd0, 1'b1);
		write_step(24'hDFF09A, 16'h7FFF, 2'b11, 1'b0, 3'd0, 1'b1);

		// ----------------------------------------------------------
		// timer a one-shot into ports
		// ----------------------------------------------------------
		write_step(24'hBFE400, 16'h0014, 2'b01, 1'b0, 3'd0, 1'b1);  // talo 20
		write_step(24'hBFE500, 16'h0000, 2'b01, 1'b0, 3'd0, 1'b1);  // tahi, loads counter
		write_step(24'hBFED00, 16'h0081, 2'b01, 1'b0, 3'd0, 1'b1);  // icr mask ta
		write_step(24'hDFF09A, 16'hC008, 2'b11, 1'b0, 3'd0, 1'b1);
		write_step(24'hBFEE00, 16'h0009, 2'b01, 1'b0, 3'd0, 1'b1);  // start, one-shot
		idle_step(16'd250, 3'd2, 1'b1);
		read_step(24'hBFED00, 16'h0081, 1'b0, 2'd0, 3'd2, 1'b1);
		read_step(24'hBFED00, 16'h0000, 1'b0, 2'd0, 3'd2, 1'b1);    // flag gone
		read_step(24'hBFEE00, 16'h0008, 1'b0, 2'd0, 3'd2, 1'b1);    // start bit dropped

		// unmapped read, rom write, rom untouched
		read_step(24'h400000, 16'h0000, 1'b1, 2'd0, 3'd2, 1'b1);
		write_step(24'hF80010, 16'h1234, 2'b11, 1'b1, 3'd2, 1'b1);
		read_step(24'hF80010, rom_pattern(24'hF80010), 1'b0, 2'd0, 3'd2, 1'b1);

		limit_ns = budget * 40 + 2000;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < steps.size(); i++) begin
			st = steps[i];
			if (st.op == OP_WAIT) begin
				repeat (st.data) @(posedge clk);
			end else begin
				bus_xfer(st, rdata, err, waits);
				if (rdata !== st.exp_data) begin   // writes return zero data
					$display("ERR %0d ns: step %0d data 0x%h at 0x%h, expected 0x%h",
						$time, i, rdata, st.addr, st.exp_data);
					err_data++;
				end
				if (err !== st.exp_err) begin
					$display("ERR %0d ns: step %0d pslverr %b at 0x%h, expected %b",
						$time, i, err, st.addr, st.exp_err);
					err_rsp++;
				end
				if (waits != st.exp_wait) begin
					$display("ERR %0d ns: step %0d took %0d wait states, expected %0d",
						$time, i, waits, st.exp_wait);
					err_rsp++;
				end
			end
			@(negedge clk);               // ipl settles one cycle after commit
			if (ipl !== st.exp_ipl) begin
				$display("ERR %0d ns: step %0d ipl %0d, expected %0d",
					$time, i, ipl, st.exp_ipl);
				err_pin++;
			end
			if (led !== st.exp_led) begin
				$display("ERR %0d ns: step %0d led %b, expected %b",
					$time, i, led, st.exp_led);
				err_pin++;
			end
		end

		$display("errors: %0d (data %0d, response %0d, pins %0d) over %0d steps",
			err_data + err_rsp + err_pin, err_data, err_rsp, err_pin, steps.size());
		if (err_data + err_rsp + err_pin == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
mc_bus_pkg.sv
mc_chip_pkg.sv
addr_decode.sv
chip_mem.sv
paula_int.sv
cia_a.sv
read_mux.sv
mini_chipset.sv
tb_mini_chipset.sv

// File: Bender.yml
package:
  name: mini_chipset

sources:
  - include_dirs:
      - .
    files:
      - mc_bus_pkg.sv
      - mc_chip_pkg.sv
      - addr_decode.sv
      - chip_mem.sv
      - paula_int.sv
      - cia_a.sv
      - read_mux.sv
      - mini_chipset.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mini_chipset.sv
